//--- acc_dispatcher_testdata.txt
# in: hs exc fu op tid rs1 flush_unissued flush_ex cons_en commit_fu commit_done commit_tid
#     st_barrier ready(0/1/r) load_cmp store_cmp store_pend; out: valid tid rs1 stall halt care
1 0 9 0 1 11 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 9 0 1 0 1 0 0 0 1 1 11 0 0 11111
1 0 9 0 2 22 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
1 0 9 0 3 33 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 9 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 1 0 10011
0 0 0 0 0 0 0 0 0 9 0 2 0 1 0 0 0 1 2 22 0 0 11111
0 0 0 0 0 0 0 0 0 9 0 3 0 1 0 0 0 1 3 33 0 0 11111
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
1 0 9 0 4 44 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
1 0 9 0 5 55 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 9 0 4 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 9 0 5 0 1 0 0 0 0 0 0 0 0 10011
1 0 9 0 6 66 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 9 0 6 0 0 0 0 0 1 6 66 0 0 11111
1 0 9 0 7 77 0 0 0 0 0 0 0 0 0 0 0 1 6 66 0 0 11111
1 0 9 0 0 a0 0 0 0 0 0 0 0 0 0 0 0 1 6 66 0 0 11111
1 0 9 0 1 b1 0 0 0 0 0 0 0 0 0 0 0 1 6 66 0 0 11111
0 0 9 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 6 66 1 0 11111
0 0 9 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 6 66 1 0 11111
0 0 9 0 0 0 0 0 0 9 0 7 0 0 0 0 0 1 6 66 1 0 11111
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1 6 66 0 0 11111
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1 7 77 0 0 11111
0 0 0 0 0 0 0 0 0 9 0 0 0 1 0 0 0 1 0 a0 0 0 11111
0 0 0 0 0 0 0 0 0 9 0 1 0 1 0 0 0 1 1 b1 0 0 11111
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
1 0 9 2 2 c2 0 0 1 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 1 0 0 0 0 0 1 0 0 0 0 1 0 0 0 0 0 0 1 0 10011
0 0 1 0 0 0 0 0 1 9 0 2 0 1 0 0 0 1 2 c2 1 0 11111
0 0 1 0 0 0 0 0 1 0 0 0 0 1 0 0 0 0 0 0 1 0 10011
0 0 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 1 0 0 0 0 0 1 0 0 0 0 1 0 1 0 0 0 0 1 0 10011
0 0 1 0 0 0 0 0 1 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 1 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0 0 0 0 1 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0 0 0 0 1 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 1 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 10011
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 10011
1 0 9 0 3 d3 0 0 0 0 0 0 0 r 0 0 0 0 0 0 0 0 00000
1 0 9 0 4 d4 0 0 0 0 0 0 0 r 0 0 0 0 0 0 0 0 00000
0 0 0 0 0 0 0 0 0 9 0 3 0 r 0 0 0 0 0 0 0 0 00000
0 0 0 0 0 0 0 0 0 9 0 4 0 r 0 0 0 0 0 0 0 0 00000
0 0 0 0 0 0 0 0 0 0 0 0 0 r 0 0 0 0 0 0 0 0 00000
0 0 0 0 0 0 0 0 0 0 0 0 0 r 0 0 0 0 0 0 0 0 00000

//--- sim.f
acc_cfg_pkg.sv
acc_insn_pkg.sv
acc_issue_capture.sv
acc_insn_queue.sv
acc_spec_tracker.sv
acc_req_dispatch.sv
acc_ldst_tracker.sv
acc_dispatcher.sv
tb_acc_dispatcher.sv

//--- tb_acc_dispatcher.sv
module tb_acc_dispatcher;

  import acc_cfg_pkg::*;
  import acc_insn_pkg::*;

  localparam int max_lines_lp     = 200;
  localparam int drain_timeout_lp = 20;
  localparam int line_chars_lp    = 160;

  // DUT inputs
  logic       clk_i;
  logic       rst_i;
  logic       issue_hs_i;
  logic       issue_exc_i;
  fu_t        issue_fu_i;
  acc_op_t    issue_op_i;
  trans_id_t  issue_trans_id_i;
  insn_word_t issue_insn_i;
  xdata_t     issue_rs1_i;
  xdata_t     issue_rs2_i;
  logic       flush_unissued_i;
  logic       flush_ex_i;
  logic       acc_cons_en_i;
  frm_t       fcsr_frm_i;
  fu_t        commit_head_fu_i;
  logic       commit_head_done_i;
  trans_id_t  commit_head_trans_id_i;
  logic       commit_st_barrier_i;
  logic       acc_req_ready_i;
  logic       acc_load_complete_i;
  logic       acc_store_complete_i;
  logic       acc_store_pending_i;

  // DUT outputs
  logic       issue_stall_o;
  logic       acc_valid_ex_o;
  logic       acc_req_valid_o;
  insn_word_t acc_req_insn_o;
  xdata_t     acc_req_rs1_o;
  xdata_t     acc_req_rs2_o;
  frm_t       acc_req_frm_o;
  trans_id_t  acc_req_trans_id_o;
  logic       ctrl_halt_o;

  // Fields of one data line, inputs first
  integer f_hs, f_exc, f_fu, f_op, f_tid, f_fun, f_fex, f_cons;
  integer f_cfu, f_cdone, f_ctid, f_bar, f_ldc, f_stc, f_stp;
  logic [63:0] f_rs1;
  logic [7:0]  f_rdy;
  // Expected values and their care mask
  integer e_valid, e_tid, e_stall, e_halt;
  logic [63:0] e_rs1;
  logic [4:0]  e_care;

  // Model state carried from one line to the next
  logic prev_accept;
  logic req_held;
  frm_t exp_frm;

  logic [8*line_chars_lp-1:0] line_buf;
  logic [31:0] lfsr_state;
  integer      fd;
  integer      code;
  integer      n_items;
  integer      line_no;
  integer      drain_cycles;
  logic        file_done;

  acc_dispatcher dut0 (.*);

  always #5 clk_i = ~clk_i;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("mismatch at time %0t: %s, got %0h, expected %0h",
                                  $time, what, got, expected));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic random_bit(output logic value);
    lfsr_state = lfsr_step(lfsr_state);
    value = lfsr_state[0];
  endtask

  // Instruction word the driver builds around an operand
  function automatic insn_word_t insn_for_rs1(input xdata_t rs1);
    return {rs1[15:0], 16'h005b};
  endfunction

  // Quiet core, accelerator always ready
  task automatic drive_idle;
    issue_hs_i             = 1'b0;
    issue_exc_i            = 1'b0;
    issue_fu_i             = fu_accel_lp;
    issue_op_i             = acc_op_other_lp;
    issue_trans_id_i       = '0;
    issue_insn_i           = '0;
    issue_rs1_i            = '0;
    issue_rs2_i            = '0;
    flush_unissued_i       = 1'b0;
    flush_ex_i             = 1'b0;
    acc_cons_en_i          = 1'b0;
    commit_head_fu_i       = '0;
    commit_head_done_i     = 1'b0;
    commit_head_trans_id_i = '0;
    commit_st_barrier_i    = 1'b0;
    acc_req_ready_i        = 1'b1;
    acc_load_complete_i    = 1'b0;
    acc_store_complete_i   = 1'b0;
    acc_store_pending_i    = 1'b0;
  endtask

  task automatic apply_inputs;
    issue_hs_i             = f_hs[0];
    issue_exc_i            = f_exc[0];
    issue_fu_i             = fu_t'(f_fu);
    issue_op_i             = acc_op_t'(f_op);
    issue_trans_id_i       = trans_id_t'(f_tid);
    // Instruction word and rs2 follow rs1 so each entry is unique
    issue_insn_i           = insn_for_rs1(f_rs1);
    issue_rs1_i            = f_rs1;
    issue_rs2_i            = ~f_rs1;
    flush_unissued_i       = f_fun[0];
    flush_ex_i             = f_fex[0];
    acc_cons_en_i          = f_cons[0];
    // Rounding mode moves every cycle so a held request must keep its own
    fcsr_frm_i             = frm_t'(line_no);
    commit_head_fu_i       = fu_t'(f_cfu);
    commit_head_done_i     = f_cdone[0];
    commit_head_trans_id_i = trans_id_t'(f_ctid);
    commit_st_barrier_i    = f_bar[0];
    acc_load_complete_i    = f_ldc[0];
    acc_store_complete_i   = f_stc[0];
    acc_store_pending_i    = f_stp[0];
    if (f_rdy == "r") begin
      random_bit(acc_req_ready_i);
    end else begin
      acc_req_ready_i = (f_rdy == "1");
    end
  endtask

  task automatic check_outputs;
    logic [4:0] care;
    // Random back-pressure leaves the outputs open
    care = (f_rdy == "r") ? 5'b00000 : e_care;
    check_value($sformatf("line %0d acc_valid_ex_o", line_no), acc_valid_ex_o,
                prev_accept);
    if (care[4]) begin
      check_value($sformatf("line %0d acc_req_valid_o", line_no), acc_req_valid_o, e_valid);
      if (e_valid != 0) begin
        // A new request samples the rounding mode, a held one keeps it
        if (!req_held) begin
          exp_frm = fcsr_frm_i;
        end
        check_value($sformatf("line %0d acc_req_frm_o", line_no), acc_req_frm_o, exp_frm);
      end
    end
    if (care[3]) begin
      check_value($sformatf("line %0d acc_req_trans_id_o", line_no), acc_req_trans_id_o,
                  e_tid);
    end
    if (care[2]) begin
      check_value($sformatf("line %0d acc_req_rs1_o", line_no), acc_req_rs1_o, e_rs1);
      check_value($sformatf("line %0d acc_req_rs2_o", line_no), acc_req_rs2_o, ~e_rs1);
      check_value($sformatf("line %0d acc_req_insn_o", line_no), acc_req_insn_o,
                  insn_for_rs1(e_rs1));
    end
    if (care[1]) begin
      check_value($sformatf("line %0d issue_stall_o", line_no), issue_stall_o, e_stall);
    end
    if (care[0]) begin
      check_value($sformatf("line %0d ctrl_halt_o", line_no), ctrl_halt_o, e_halt);
    end
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    fcsr_frm_i  = 3'd1;
    drive_idle();
    lfsr_state  = 32'h2bbd0895;
    file_done   = 1'b0;
    line_no     = 0;
    prev_accept = 1'b0;
    req_held    = 1'b0;
    exp_frm     = '0;
    fd = $fopen("acc_dispatcher_testdata.txt", "r");
    if (fd == 0) begin
      stop_with_failure("cannot open acc_dispatcher_testdata.txt for reading");
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // One data line per cycle, driven after the edge and checked before the next
    for (int i = 0; i < max_lines_lp && !file_done; i++) begin
      line_buf = '0;
      code     = $fgets(line_buf, fd);
      line_no  = line_no + 1;
      if (code == 0) begin
        file_done = 1'b1;
      end else begin
        n_items = $sscanf(line_buf,
          "%d %d %d %d %d %h %d %d %d %d %d %d %d %s %d %d %d %d %d %h %d %d %b",
          f_hs, f_exc, f_fu, f_op, f_tid, f_rs1, f_fun, f_fex, f_cons,
          f_cfu, f_cdone, f_ctid, f_bar, f_rdy, f_ldc, f_stc, f_stp,
          e_valid, e_tid, e_rs1, e_stall, e_halt, e_care);
        // Comment and blank lines yield no fields
        if (n_items > 0 && n_items != 23) begin
          stop_with_failure($sformatf("data file line %0d has %0d fields instead of 23",
                                      line_no, n_items));
        end else if (n_items == 23) begin
          apply_inputs();
          #8;
          check_outputs();
          // Accepted accelerator handshake shows up in execute one cycle later
          prev_accept = f_hs[0] && (fu_t'(f_fu) == fu_accel_lp) && !f_exc[0] && !f_fun[0];
          // Request not taken by the accelerator stays in the register
          req_held = (f_rdy != "r") && e_care[4] && (e_valid != 0) && !acc_req_ready_i;
          @(posedge clk_i);
          #1;
        end
      end
    end
    if (!file_done) begin
      stop_with_failure("data file did not end within the line limit");
    end
    // Let held and ready requests leave
    drive_idle();
    drain_cycles = 0;
    #8;
    while (acc_req_valid_o !== 1'b0 && drain_cycles < drain_timeout_lp) begin
      @(posedge clk_i);
      #8;
      drain_cycles = drain_cycles + 1;
    end
    if (acc_req_valid_o !== 1'b0) begin
      stop_with_failure("accelerator request still valid after the drain timeout");
    end else begin
      check_value("issue_stall_o after drain", issue_stall_o, 64'd0);
      check_value("ctrl_halt_o after drain", ctrl_halt_o, 64'd0);
      $fclose(fd);
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

//--- acc_dispatcher.sv
module acc_dispatcher (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    issue_hs_i,
  input  logic                    issue_exc_i,
  input  acc_insn_pkg::fu_t       issue_fu_i,
  input  acc_insn_pkg::acc_op_t   issue_op_i,
  input  acc_cfg_pkg::trans_id_t  issue_trans_id_i,
  input  acc_cfg_pkg::insn_word_t issue_insn_i,
  input  acc_cfg_pkg::xdata_t     issue_rs1_i,
  input  acc_cfg_pkg::xdata_t     issue_rs2_i,
  input  logic                    flush_unissued_i,
  input  logic                    flush_ex_i,
  input  logic                    acc_cons_en_i,
  input  acc_insn_pkg::frm_t      fcsr_frm_i,
  input  acc_insn_pkg::fu_t       commit_head_fu_i,
  input  logic                    commit_head_done_i,
  input  acc_cfg_pkg::trans_id_t  commit_head_trans_id_i,
  input  logic                    commit_st_barrier_i,
  input  logic                    acc_req_ready_i,
  input  logic                    acc_load_complete_i,
  input  logic                    acc_store_complete_i,
  input  logic                    acc_store_pending_i,
  output logic                    issue_stall_o,
  output logic                    acc_valid_ex_o,
  output logic                    acc_req_valid_o,
  output acc_cfg_pkg::insn_word_t acc_req_insn_o,
  output acc_cfg_pkg::xdata_t     acc_req_rs1_o,
  output acc_cfg_pkg::xdata_t     acc_req_rs2_o,
  output acc_insn_pkg::frm_t      acc_req_frm_o,
  output acc_cfg_pkg::trans_id_t  acc_req_trans_id_o,
  output logic                    ctrl_halt_o
);

  import acc_cfg_pkg::*;
  import acc_insn_pkg::*;

  // Capture to queue and trackers
  logic         cap_valid;
  insn_word_t   cap_insn;
  xdata_t       cap_rs1;
  xdata_t       cap_rs2;
  trans_id_t    cap_trans_id;
  acc_op_t      cap_op;
  logic         issue_ld;
  logic         issue_st;

  // Queue to dispatch
  logic         q_empty;
  queue_usage_t q_usage;
  logic         q_pop;
  insn_word_t   head_insn;
  xdata_t       head_rs1;
  xdata_t       head_rs2;
  trans_id_t    head_trans_id;
  acc_op_t      head_op;

  // Speculation state
  sb_mask_t     ready_mask;
  logic         commit_now;
  trans_id_t    commit_trans_id;
  logic         req_fire;
  trans_id_t    req_fire_trans_id;

  // Load/store accounting
  logic         disp_ld;
  logic         disp_st;
  logic         no_ld_pending;
  logic         no_st_pending;

  // Execute-stage valid is the captured instruction
  assign acc_valid_ex_o = cap_valid;

  acc_issue_capture u_capture (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .issue_hs_i       (issue_hs_i),
    .issue_exc_i      (issue_exc_i),
    .issue_fu_i       (issue_fu_i),
    .issue_op_i       (issue_op_i),
    .issue_trans_id_i (issue_trans_id_i),
    .issue_insn_i     (issue_insn_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_rs2_i      (issue_rs2_i),
    .flush_unissued_i (flush_unissued_i),
    .acc_cons_en_i    (acc_cons_en_i),
    .q_usage_i        (q_usage),
    .no_ld_pending_i  (no_ld_pending),
    .no_st_pending_i  (no_st_pending),
    .issue_stall_o    (issue_stall_o),
    .cap_valid_o      (cap_valid),
    .cap_insn_o       (cap_insn),
    .cap_rs1_o        (cap_rs1),
    .cap_rs2_o        (cap_rs2),
    .cap_trans_id_o   (cap_trans_id),
    .cap_op_o         (cap_op),
    .issue_ld_o       (issue_ld),
    .issue_st_o       (issue_st)
  );

  acc_insn_queue u_queue (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .flush_i         (flush_ex_i),
    .push_i          (cap_valid),
    .push_insn_i     (cap_insn),
    .push_rs1_i      (cap_rs1),
    .push_rs2_i      (cap_rs2),
    .push_trans_id_i (cap_trans_id),
    .push_op_i       (cap_op),
    .pop_i           (q_pop),
    .empty_o         (q_empty),
    .usage_o         (q_usage),
    .head_insn_o     (head_insn),
    .head_rs1_o      (head_rs1),
    .head_rs2_o      (head_rs2),
    .head_trans_id_o (head_trans_id),
    .head_op_o       (head_op)
  );

  acc_spec_tracker u_spec (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .cap_valid_i            (cap_valid),
    .cap_trans_id_i         (cap_trans_id),
    .flush_ex_i             (flush_ex_i),
    .flush_unissued_i       (flush_unissued_i),
    .commit_head_fu_i       (commit_head_fu_i),
    .commit_head_done_i     (commit_head_done_i),
    .commit_head_trans_id_i (commit_head_trans_id_i),
    .req_fire_i             (req_fire),
    .req_fire_trans_id_i    (req_fire_trans_id),
    .ready_mask_o           (ready_mask),
    .commit_now_o           (commit_now),
    .commit_trans_id_o      (commit_trans_id)
  );

  acc_req_dispatch u_dispatch (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .q_empty_i           (q_empty),
    .head_insn_i         (head_insn),
    .head_rs1_i          (head_rs1),
    .head_rs2_i          (head_rs2),
    .head_trans_id_i     (head_trans_id),
    .head_op_i           (head_op),
    .ready_mask_i        (ready_mask),
    .commit_now_i        (commit_now),
    .commit_trans_id_i   (commit_trans_id),
    .fcsr_frm_i          (fcsr_frm_i),
    .acc_req_ready_i     (acc_req_ready_i),
    .q_pop_o             (q_pop),
    .disp_ld_o           (disp_ld),
    .disp_st_o           (disp_st),
    .req_fire_o          (req_fire),
    .req_fire_trans_id_o (req_fire_trans_id),
    .acc_req_valid_o     (acc_req_valid_o),
    .acc_req_insn_o      (acc_req_insn_o),
    .acc_req_rs1_o       (acc_req_rs1_o),
    .acc_req_rs2_o       (acc_req_rs2_o),
    .acc_req_frm_o       (acc_req_frm_o),
    .acc_req_trans_id_o  (acc_req_trans_id_o)
  );

  acc_ldst_tracker u_ldst (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .flush_ex_i           (flush_ex_i),
    .issue_ld_i           (issue_ld),
    .issue_st_i           (issue_st),
    .disp_ld_i            (disp_ld),
    .disp_st_i            (disp_st),
    .acc_load_complete_i  (acc_load_complete_i),
    .acc_store_complete_i (acc_store_complete_i),
    .acc_store_pending_i  (acc_store_pending_i),
    .commit_st_barrier_i  (commit_st_barrier_i),
    .no_ld_pending_o      (no_ld_pending),
    .no_st_pending_o      (no_st_pending),
    .ctrl_halt_o          (ctrl_halt_o)
  );

endmodule

//--- acc_ldst_tracker.sv
module acc_ldst_tracker (
  input  logic clk_i,
  input  logic rst_i,
  input  logic flush_ex_i,
  input  logic issue_ld_i,
  input  logic issue_st_i,
  input  logic disp_ld_i,
  input  logic disp_st_i,
  input  logic acc_load_complete_i,
  input  logic acc_store_complete_i,
  input  logic acc_store_pending_i,
  input  logic commit_st_barrier_i,
  output logic no_ld_pending_o,
  output logic no_st_pending_o,
  output logic ctrl_halt_o
);

  import acc_cfg_pkg::*;

  // Issued but not dispatched, can still be flushed
  pend_cnt_t spec_ld_q;
  pend_cnt_t spec_st_q;
  // Dispatched and not yet completed by the accelerator
  pend_cnt_t disp_ld_q;
  pend_cnt_t disp_st_q;

  function automatic pend_cnt_t cnt_step(pend_cnt_t cnt, logic up, logic dn);
    return cnt + pend_cnt_t'(up) - pend_cnt_t'(dn);
  endfunction

  assign no_ld_pending_o = (spec_ld_q == '0) && (disp_ld_q == '0);
  assign no_st_pending_o = (spec_st_q == '0) && (disp_st_q == '0);

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_ex_i) begin
      spec_ld_q <= '0;
      spec_st_q <= '0;
    end else begin
      spec_ld_q <= cnt_step(spec_ld_q, issue_ld_i, disp_ld_i);
      spec_st_q <= cnt_step(spec_st_q, issue_st_i, disp_st_i);
    end
  end

  // Flush does not touch accesses already handed over
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      disp_ld_q <= '0;
      disp_st_q <= '0;
    end else begin
      disp_ld_q <= cnt_step(disp_ld_q, disp_ld_i, acc_load_complete_i);
      disp_st_q <= cnt_step(disp_st_q, disp_st_i, acc_store_complete_i);
    end
  end

  // Store barrier halts the controller until accelerator stores drain
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_halt_o <= 1'b0;
    end else begin
      ctrl_halt_o <= (ctrl_halt_o || commit_st_barrier_i) && acc_store_pending_i;
    end
  end

endmodule

//--- acc_req_dispatch.sv
module acc_req_dispatch (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    q_empty_i,
  input  acc_cfg_pkg::insn_word_t head_insn_i,
  input  acc_cfg_pkg::xdata_t     head_rs1_i,
  input  acc_cfg_pkg::xdata_t     head_rs2_i,
  input  acc_cfg_pkg::trans_id_t  head_trans_id_i,
  input  acc_insn_pkg::acc_op_t   head_op_i,
  input  acc_cfg_pkg::sb_mask_t   ready_mask_i,
  input  logic                    commit_now_i,
  input  acc_cfg_pkg::trans_id_t  commit_trans_id_i,
  input  acc_insn_pkg::frm_t      fcsr_frm_i,
  input  logic                    acc_req_ready_i,
  output logic                    q_pop_o,
  output logic                    disp_ld_o,
  output logic                    disp_st_o,
  output logic                    req_fire_o,
  output acc_cfg_pkg::trans_id_t  req_fire_trans_id_o,
  output logic                    acc_req_valid_o,
  output acc_cfg_pkg::insn_word_t acc_req_insn_o,
  output acc_cfg_pkg::xdata_t     acc_req_rs1_o,
  output acc_cfg_pkg::xdata_t     acc_req_rs2_o,
  output acc_insn_pkg::frm_t      acc_req_frm_o,
  output acc_cfg_pkg::trans_id_t  acc_req_trans_id_o
);

  import acc_cfg_pkg::*;
  import acc_insn_pkg::*;

  logic       head_valid;
  logic       full_q;
  insn_word_t insn_q;
  xdata_t     rs1_q;
  xdata_t     rs2_q;
  frm_t       frm_q;
  trans_id_t  tid_q;

  // Head is non-speculative, either already promoted or committing now
  assign head_valid = !q_empty_i &&
                      (ready_mask_i[head_trans_id_i] ||
                       (commit_now_i && (commit_trans_id_i == head_trans_id_i)));

  // Register takes a new request only while it holds none
  assign q_pop_o   = head_valid && !full_q;
  assign disp_ld_o = q_pop_o && (head_op_i == acc_op_load_lp);
  assign disp_st_o = q_pop_o && (head_op_i == acc_op_store_lp);

  // Fall-through toward the accelerator
  assign acc_req_valid_o    = full_q || head_valid;
  assign acc_req_insn_o     = full_q ? insn_q : head_insn_i;
  assign acc_req_rs1_o      = full_q ? rs1_q : head_rs1_i;
  assign acc_req_rs2_o      = full_q ? rs2_q : head_rs2_i;
  // Rounding mode is current at dispatch since the core commits in order
  assign acc_req_frm_o      = full_q ? frm_q : fcsr_frm_i;
  assign acc_req_trans_id_o = full_q ? tid_q : head_trans_id_i;

  assign req_fire_o          = acc_req_valid_o && acc_req_ready_i;
  assign req_fire_trans_id_o = acc_req_trans_id_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Held request leaves on ready
      full_q <= !acc_req_ready_i;
    end else begin
      // Popped but not taken, keep it
      full_q <= head_valid && !acc_req_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!full_q && head_valid) begin
      insn_q <= head_insn_i;
      rs1_q  <= head_rs1_i;
      rs2_q  <= head_rs2_i;
      frm_q  <= fcsr_frm_i;
      tid_q  <= head_trans_id_i;
    end
  end

endmodule

//--- acc_spec_tracker.sv
module acc_spec_tracker (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cap_valid_i,
  input  acc_cfg_pkg::trans_id_t cap_trans_id_i,
  input  logic                   flush_ex_i,
  input  logic                   flush_unissued_i,
  input  acc_insn_pkg::fu_t      commit_head_fu_i,
  input  logic                   commit_head_done_i,
  input  acc_cfg_pkg::trans_id_t commit_head_trans_id_i,
  input  logic                   req_fire_i,
  input  acc_cfg_pkg::trans_id_t req_fire_trans_id_i,
  output acc_cfg_pkg::sb_mask_t  ready_mask_o,
  output logic                   commit_now_o,
  output acc_cfg_pkg::trans_id_t commit_trans_id_o
);

  import acc_cfg_pkg::*;
  import acc_insn_pkg::*;

  // Received by the dispatcher, still speculative
  sb_mask_t pending_q;
  sb_mask_t pending_d;
  // Reached the scoreboard head, not yet sent
  sb_mask_t ready_q;
  sb_mask_t ready_d;
  logic     head_commit;

  // Head of the scoreboard is an accelerator op that has not completed
  assign head_commit = (commit_head_fu_i == fu_accel_lp) && !commit_head_done_i;

  assign commit_now_o      = head_commit && pending_q[commit_head_trans_id_i] &&
                             !flush_unissued_i;
  assign commit_trans_id_o = commit_head_trans_id_i;
  assign ready_mask_o      = ready_q;

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    if (cap_valid_i) begin
      pending_d[cap_trans_id_i] = 1'b1;
    end
    // Flush drops everything not yet promoted
    if (flush_ex_i) begin
      pending_d = '0;
    end
    // Promote from pending to ready
    if (head_commit && pending_q[commit_head_trans_id_i]) begin
      ready_d[commit_head_trans_id_i]   = 1'b1;
      pending_d[commit_head_trans_id_i] = 1'b0;
    end
    // Sent to the accelerator, wins over a promotion in the same cycle
    if (req_fire_i) begin
      ready_d[req_fire_trans_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

endmodule

//--- acc_insn_queue.sv
module acc_insn_queue (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic                      push_i,
  input  acc_cfg_pkg::insn_word_t   push_insn_i,
  input  acc_cfg_pkg::xdata_t       push_rs1_i,
  input  acc_cfg_pkg::xdata_t       push_rs2_i,
  input  acc_cfg_pkg::trans_id_t    push_trans_id_i,
  input  acc_insn_pkg::acc_op_t     push_op_i,
  input  logic                      pop_i,
  output logic                      empty_o,
  output acc_cfg_pkg::queue_usage_t usage_o,
  output acc_cfg_pkg::insn_word_t   head_insn_o,
  output acc_cfg_pkg::xdata_t       head_rs1_o,
  output acc_cfg_pkg::xdata_t       head_rs2_o,
  output acc_cfg_pkg::trans_id_t    head_trans_id_o,
  output acc_insn_pkg::acc_op_t     head_op_o
);

  import acc_cfg_pkg::*;
  import acc_insn_pkg::*;

  insn_word_t insn_mem [insn_queue_depth_lp];
  xdata_t     rs1_mem  [insn_queue_depth_lp];
  xdata_t     rs2_mem  [insn_queue_depth_lp];
  trans_id_t  tid_mem  [insn_queue_depth_lp];
  acc_op_t    op_mem   [insn_queue_depth_lp];

  queue_ptr_t   rd_ptr_q;
  queue_ptr_t   wr_ptr_q;
  queue_usage_t usage_q;
  logic         full;
  logic         stored_empty;
  logic         do_push;
  logic         do_pop;
  logic         bypass;

  function automatic queue_ptr_t ptr_inc(queue_ptr_t ptr);
    // Wrap at the last slot since the depth is not a power of two
    if (ptr == queue_ptr_t'(insn_queue_depth_lp - 1)) begin
      return '0;
    end
    return ptr + queue_ptr_t'(1);
  endfunction

  assign stored_empty = usage_q == '0;
  assign full         = usage_q == queue_usage_t'(insn_queue_depth_lp);

  // Empty queue shows the incoming entry at the head
  assign empty_o = stored_empty && !push_i;
  assign usage_o = usage_q;

  // Push and pop of the same entry on an empty queue skip storage
  assign bypass  = stored_empty && push_i && pop_i;
  assign do_push = push_i && !full && !bypass;
  assign do_pop  = pop_i && !stored_empty;

  assign head_insn_o     = stored_empty ? push_insn_i     : insn_mem[rd_ptr_q];
  assign head_rs1_o      = stored_empty ? push_rs1_i      : rs1_mem[rd_ptr_q];
  assign head_rs2_o      = stored_empty ? push_rs2_i      : rs2_mem[rd_ptr_q];
  assign head_trans_id_o = stored_empty ? push_trans_id_i : tid_mem[rd_ptr_q];
  assign head_op_o       = stored_empty ? push_op_i       : op_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Net fill change
      if (do_push && !do_pop) begin
        usage_q <= usage_q + queue_usage_t'(1);
      end else if (do_pop && !do_push) begin
        usage_q <= usage_q - queue_usage_t'(1);
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      insn_mem[wr_ptr_q] <= push_insn_i;
      rs1_mem[wr_ptr_q]  <= push_rs1_i;
      rs2_mem[wr_ptr_q]  <= push_rs2_i;
      tid_mem[wr_ptr_q]  <= push_trans_id_i;
      op_mem[wr_ptr_q]   <= push_op_i;
    end
  end

endmodule

//--- acc_issue_capture.sv
module acc_issue_capture (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    issue_hs_i,
  input  logic                    issue_exc_i,
  input  acc_insn_pkg::fu_t       issue_fu_i,
  input  acc_insn_pkg::acc_op_t   issue_op_i,
  input  acc_cfg_pkg::trans_id_t  issue_trans_id_i,
  input  acc_cfg_pkg::insn_word_t issue_insn_i,
  input  acc_cfg_pkg::xdata_t     issue_rs1_i,
  input  acc_cfg_pkg::xdata_t     issue_rs2_i,
  input  logic                    flush_unissued_i,
  input  logic                    acc_cons_en_i,
  input  acc_cfg_pkg::queue_usage_t q_usage_i,
  input  logic                    no_ld_pending_i,
  input  logic                    no_st_pending_i,
  output logic                    issue_stall_o,
  output logic                    cap_valid_o,
  output acc_cfg_pkg::insn_word_t cap_insn_o,
  output acc_cfg_pkg::xdata_t     cap_rs1_o,
  output acc_cfg_pkg::xdata_t     cap_rs2_o,
  output acc_cfg_pkg::trans_id_t  cap_trans_id_o,
  output acc_insn_pkg::acc_op_t   cap_op_o,
  output logic                    issue_ld_o,
  output logic                    issue_st_o
);

  import acc_cfg_pkg::*;
  import acc_insn_pkg::*;

  logic accept;

  // Accelerator instruction leaves issue without exception or flush
  assign accept = issue_hs_i && (issue_fu_i == fu_accel_lp) && !issue_exc_i &&
                  !flush_unissued_i;

  // Counter pulses in the handshake cycle itself
  assign issue_ld_o = accept && (issue_op_i == acc_op_load_lp);
  assign issue_st_o = accept && (issue_op_i == acc_op_store_lp);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cap_valid_o <= 1'b0;
    end else begin
      cap_valid_o <= accept;
    end
  end

  // Payload only moves with an accepted instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cap_insn_o     <= issue_insn_i;
      cap_rs1_o      <= issue_rs1_i;
      cap_rs2_o      <= issue_rs2_i;
      cap_trans_id_o <= issue_trans_id_i;
      cap_op_o       <= issue_op_i;
    end
  end

  always_comb begin
    case (issue_fu_i)
      // Queue must keep one slot for the instruction already in capture
      fu_accel_lp: issue_stall_o = q_usage_i >= queue_usage_t'(insn_queue_depth_lp - 1);
      // Scalar load waits for accelerator stores in consistency mode
      fu_load_lp:  issue_stall_o = acc_cons_en_i && !no_st_pending_i;
      // Scalar store waits for any accelerator memory access
      fu_store_lp: issue_stall_o = acc_cons_en_i && (!no_st_pending_i || !no_ld_pending_i);
      default:     issue_stall_o = 1'b0;
    endcase
  end

endmodule

//--- acc_insn_pkg.sv
package acc_insn_pkg;

  // Functional unit selected by the decoder
  typedef logic [3:0] fu_t;

  localparam fu_t fu_load_lp  = 4'd1;
  localparam fu_t fu_store_lp = 4'd2;
  localparam fu_t fu_accel_lp = 4'd9;

  // Memory class of an accelerator operation
  typedef logic [1:0] acc_op_t;

  localparam acc_op_t acc_op_other_lp = 2'd0;
  localparam acc_op_t acc_op_load_lp  = 2'd1;
  localparam acc_op_t acc_op_store_lp = 2'd2;

  // Floating-point rounding mode from fcsr
  typedef logic [2:0] frm_t;

endpackage

//--- acc_cfg_pkg.sv
package acc_cfg_pkg;

  // Instruction queue between capture and dispatch
  localparam int insn_queue_depth_lp = 3;

  // Scoreboard geometry of the core
  localparam int trans_id_width_lp = 3;
  localparam int nr_sb_entries_lp  = 8;

  // Operand width
  localparam int xlen_lp = 64;

  // In-flight load/store counters
  localparam int pend_cnt_width_lp = 3;

  // Scoreboard transaction ID
  typedef logic [trans_id_width_lp-1:0] trans_id_t;

  // Operand as read from the register file
  typedef logic [xlen_lp-1:0] xdata_t;

  // Raw accelerator instruction word
  typedef logic [31:0] insn_word_t;

  // One bit per scoreboard entry
  typedef logic [nr_sb_entries_lp-1:0] sb_mask_t;

  // Pending-access count
  typedef logic [pend_cnt_width_lp-1:0] pend_cnt_t;

  // Queue fill level, 0 up to the full depth
  typedef logic [$clog2(insn_queue_depth_lp+1)-1:0] queue_usage_t;

  // Queue slot index
  typedef logic [$clog2(insn_queue_depth_lp)-1:0] queue_ptr_t;

endpackage
